// ==== Makefile ====
# Verilator build and run of the UART testbench.
VERILATOR ?= verilator
TOP       ?= uart_tb
SEED      ?= 955675319
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets and variables"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP SEED FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -GSEED=$(SEED) \
		-Mdir $(BUILD_DIR) -f $(FLIST)
	$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== flist.f ====
src/uart_pkg.sv
src/uart_core_if.sv
src/uart_wb_regs.sv
src/uart_tx.sv
src/uart_rx.sv
src/uart_top.sv
verification/uart_chk.sv
verification/uart_tb.sv

// ==== src/uart_core_if.sv ====
// Interface between the register block and the transmit and receive engines.
`timescale 1ns/10ps
`default_nettype none

interface uart_core_if import uart_pkg::*; ();

    // Configuration.
    word_t cfg_div;  // Bit time is cfg_div + 2 clocks.
    logic  div_wr;   // One-cycle pulse on a divider write.

    // Transmit side.
    logic  tx_we;    // Load tx_byte into the transmitter.
    byte_t tx_byte;
    logic  tx_busy;  // Frame or quiet period in progress.

    // Receive side.
    byte_t rx_byte;
    logic  rx_valid; // Holding register has an unread byte.
    logic  rx_re;    // Data read, clears rx_valid.

    modport regs (
        output cfg_div, div_wr,
        output tx_we, tx_byte,
        input  tx_busy,
        input  rx_byte, rx_valid,
        output rx_re
    );

    modport tx (
        input  cfg_div, div_wr,
        input  tx_we, tx_byte,
        output tx_busy
    );

    modport rx (
        input  cfg_div,
        output rx_byte, rx_valid,
        input  rx_re
    );

endinterface

`default_nettype wire

// ==== src/uart_pkg.sv ====
// UART package with bus and byte types, register offsets, reset and frame constants.
`default_nettype none

package uart_pkg;

    // Bus and serial data types.
    typedef logic [31:0] word_t;
    typedef logic [7:0]  byte_t;

    // Register offsets from the base address.
    localparam word_t REG_DIV_OFS = 32'h0000_0000; // Clock divider.
    localparam word_t REG_DAT_OFS = 32'h0000_0004; // Transmit and receive data.

    // Divider after reset, giving a bit time of three clocks.
    localparam word_t DIV_RESET = 32'd1;

    // Idle bit times sent after reset and after each divider write.
    localparam logic [3:0] QUIET_BITS = 4'd15;

    // Start bit, eight data bits and one stop bit.
    localparam logic [3:0] FRAME_BITS = 4'd10;

    // Read value of the data register when no byte is waiting.
    localparam word_t RX_EMPTY = 32'hFFFF_FFFF;

endpackage

`default_nettype wire

// ==== src/uart_rx.sv ====
// UART receive engine with start detect, mid-bit sampling and a holding register.
`timescale 1ns/10ps
`default_nettype none

module uart_rx import uart_pkg::*; (
    input  wire logic clk,
    input  wire logic resetn,
    input  wire logic ser_rx_i,
    uart_core_if.rx   core
);

    // State counter values; data bits use the states in between.
    localparam logic [3:0] ST_IDLE  = 4'd0;
    localparam logic [3:0] ST_HALF  = 4'd1;
    localparam logic [3:0] ST_DAT7  = 4'd9;
    localparam logic [3:0] ST_STOP  = 4'd10;

    logic [3:0] state;
    word_t      divcnt;
    byte_t      shift;     // Bits arrive LSB first.
    byte_t      hold;
    logic       valid;
    logic       half_done;
    logic       bit_done;

    // Half a bit time, compared with one extra bit to avoid overflow.
    assign half_done = {divcnt, 1'b0} > {1'b0, core.cfg_div};
    assign bit_done  = divcnt > core.cfg_div;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state  <= ST_IDLE;
            divcnt <= '0;
            valid  <= 1'b0;
        end else begin
            divcnt <= divcnt + 32'd1;

            if (core.rx_re)
                valid <= 1'b0;

            case (state)
                ST_IDLE: begin
                    divcnt <= '0;
                    if (!ser_rx_i)
                        state <= ST_HALF;         // Start bit edge.
                end
                ST_HALF: begin
                    if (half_done) begin
                        state  <= state + 4'd1;
                        divcnt <= '0;
                    end
                end
                ST_STOP: begin
                    if (bit_done) begin
                        valid <= 1'b1;            // Wins over a same-cycle read.
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    if (bit_done) begin
                        state  <= state + 4'd1;
                        divcnt <= '0;
                    end
                end
            endcase
        end
    end

    // Data path without reset.
    always_ff @(posedge clk) begin
        if (state > ST_HALF && state <= ST_DAT7 && bit_done)
            shift <= {ser_rx_i, shift[7:1]};
        if (state == ST_STOP && bit_done)
            hold <= shift;
    end

    assign core.rx_byte  = hold;
    assign core.rx_valid = valid;

endmodule

`default_nettype wire

// ==== src/uart_top.sv ====
// UART top level with Wishbone and serial ports, register block and both engines.
`timescale 1ns/10ps
`default_nettype none

module uart_top import uart_pkg::*; #(
    parameter word_t BASE_ADR = 32'h2000_0000
) (
    input  wire logic       clk,
    input  wire logic       resetn,

    // Wishbone classic slave.
    input  wire word_t      adr_i,
    input  wire word_t      dat_i,
    input  wire logic [3:0] sel_i,
    input  wire logic       we_i,
    input  wire logic       cyc_i,
    input  wire logic       stb_i,
    output logic            ack_o,
    output word_t           dat_o,

    // Serial line.
    input  wire logic       ser_rx_i,
    output logic            ser_tx_o
);

    uart_core_if core0 ();

    uart_wb_regs #(
        .BASE_ADR (BASE_ADR)
    ) regs0 (
        .clk    (clk),
        .resetn (resetn),
        .adr_i  (adr_i),
        .dat_i  (dat_i),
        .sel_i  (sel_i),
        .we_i   (we_i),
        .cyc_i  (cyc_i),
        .stb_i  (stb_i),
        .ack_o  (ack_o),
        .dat_o  (dat_o),
        .core   (core0.regs)
    );

    // Transmit engine, owns ser_tx_o.
    uart_tx tx0 (
        .clk      (clk),
        .resetn   (resetn),
        .core     (core0.tx),
        .ser_tx_o (ser_tx_o)
    );

    // Receive engine.
    uart_rx rx0 (
        .clk      (clk),
        .resetn   (resetn),
        .ser_rx_i (ser_rx_i),
        .core     (core0.rx)
    );

endmodule

`default_nettype wire

// ==== src/uart_tx.sv ====
// UART transmit engine sending 8N1 frames and the quiet-line period.
`timescale 1ns/10ps
`default_nettype none

module uart_tx import uart_pkg::*; (
    input  wire logic clk,
    input  wire logic resetn,
    uart_core_if.tx   core,
    output logic      ser_tx_o
);

    logic [9:0] pattern;    // Bit 0 is on the line.
    logic [3:0] bitcnt;     // Bit times left in the current frame.
    word_t      divcnt;
    logic       quiet_pend; // Quiet period requested.
    logic       bit_end;

    // Last clock of the current bit time.
    assign bit_end = (bitcnt != 4'd0) && (divcnt > core.cfg_div);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            pattern    <= '1;
            bitcnt     <= 4'd0;
            divcnt     <= '0;
            quiet_pend <= 1'b1;   // Line stays quiet after reset.
        end else begin
            if (bit_end) begin
                pattern <= {1'b1, pattern[9:1]};
                bitcnt  <= bitcnt - 4'd1;
                divcnt  <= '0;
            end else if (bitcnt != 4'd0) begin
                divcnt <= divcnt + 32'd1;
            end else if (quiet_pend) begin
                // Idle frame, all ones.
                pattern    <= '1;
                bitcnt     <= QUIET_BITS;
                divcnt     <= '0;
                quiet_pend <= 1'b0;
            end else if (core.tx_we) begin
                pattern <= {1'b1, core.tx_byte, 1'b0}; // Stop, data, start.
                bitcnt  <= FRAME_BITS;
                divcnt  <= '0;
            end

            // New divider always queues another quiet period.
            if (core.div_wr)
                quiet_pend <= 1'b1;
        end
    end

    assign ser_tx_o     = pattern[0];
    assign core.tx_busy = (bitcnt != 4'd0) || quiet_pend;

endmodule

`default_nettype wire

// ==== src/uart_wb_regs.sv ====
// Wishbone classic slave with address decode, divider register and data steering.
`timescale 1ns/10ps
`default_nettype none

module uart_wb_regs import uart_pkg::*; #(
    parameter word_t BASE_ADR = 32'h2000_0000
) (
    input  wire logic  clk,
    input  wire logic  resetn,
    input  wire word_t adr_i,
    input  wire word_t dat_i,
    input  wire logic [3:0] sel_i,
    input  wire logic  we_i,
    input  wire logic  cyc_i,
    input  wire logic  stb_i,
    output logic       ack_o,
    output word_t      dat_o,
    uart_core_if.regs  core
);

    localparam word_t DIV_ADR = BASE_ADR + REG_DIV_OFS;
    localparam word_t DAT_ADR = BASE_ADR + REG_DAT_OFS;

    logic  valid;
    logic  div_sel;
    logic  dat_sel;
    logic  dat_stall;
    word_t cfg_div;

    assign valid   = cyc_i && stb_i;
    assign div_sel = valid && (adr_i == DIV_ADR);
    assign dat_sel = valid && (adr_i == DAT_ADR);

    // A data write waits while a frame or quiet period is running.
    assign dat_stall = dat_sel && we_i && core.tx_busy;

    // Divider with byte-lane write enables.
    always_ff @(posedge clk) begin
        if (!resetn) begin
            cfg_div <= DIV_RESET;
        end else if (div_sel && we_i) begin
            for (int i = 0; i < 4; i++) begin
                if (sel_i[i])
                    cfg_div[8*i +: 8] <= dat_i[8*i +: 8];
            end
        end
    end

    assign core.cfg_div = cfg_div;
    assign core.div_wr  = div_sel && we_i;        // Restarts the quiet period.

    assign core.tx_we   = dat_sel && we_i && !core.tx_busy;
    assign core.tx_byte = dat_i[7:0];
    assign core.rx_re   = dat_sel && !we_i;

    // Read data, zero-extended byte or the empty marker.
    always_comb begin
        if (div_sel)
            dat_o = cfg_div;
        else if (core.rx_valid)
            dat_o = {24'h00_0000, core.rx_byte};
        else
            dat_o = RX_EMPTY;
    end

    // Same-cycle ack for mapped addresses only.
    assign ack_o = (div_sel || dat_sel) && !dat_stall;

endmodule

`default_nettype wire

// ==== verification/uart_chk.sv ====
// Bound checker with concurrent assertions on the Wishbone ack and the transmit line.
`timescale 1ns/10ps
`default_nettype none

module uart_chk import uart_pkg::*; #(
    parameter word_t BASE_ADR = 32'h2000_0000
) (
    input wire logic  clk,
    input wire logic  resetn,
    input wire word_t adr_i,
    input wire logic  we_i,
    input wire logic  cyc_i,
    input wire logic  stb_i,
    input wire logic  ack_i,
    input wire logic  ser_tx_i
);

    localparam word_t DAT_ADR = BASE_ADR + REG_DAT_OFS;

    // Ack only inside a valid bus cycle.
    a_ack_in_cycle: assert property (@(posedge clk) ack_i |-> (cyc_i && stb_i))
        else $error("ack_o high without cyc_i and stb_i");

    a_tx_idle_reset: assert property (@(posedge clk) !resetn |=> ser_tx_i)
        else $error("ser_tx_o not high during reset");

    // First cycle out of reset.
    a_tx_idle_after: assert property (@(posedge clk) $rose(resetn) |=> ser_tx_i)
        else $error("ser_tx_o not high on the cycle after reset");

    // An acked data write starts its frame on the next cycle.
    a_no_ack_mid_frame: assert property (@(posedge clk) disable iff (!resetn)
        (ack_i && we_i && (adr_i == DAT_ADR)) |=> !ser_tx_i)
        else $error("data write acked while the line was mid-frame");

endmodule

bind uart_top uart_chk #(
    .BASE_ADR (BASE_ADR)
) chk0 (
    .clk      (clk),
    .resetn   (resetn),
    .adr_i    (adr_i),
    .we_i     (we_i),
    .cyc_i    (cyc_i),
    .stb_i    (stb_i),
    .ack_i    (ack_o),
    .ser_tx_i (ser_tx_o)
);

`default_nettype wire

// ==== verification/uart_tb.sv ====
// UART testbench with clock, reset, bus and serial tasks, reference model, checks and watchdog.
`timescale 1ns/10ps
`default_nettype none

module uart_tb import uart_pkg::*; #(
    parameter int unsigned SEED = 32'h38f672b7
);

    localparam int    CLK_PERIOD   = 20;
    localparam word_t BASE_ADR     = 32'h2000_0000;
    localparam word_t DIV_ADR      = BASE_ADR + REG_DIV_OFS;
    localparam word_t DAT_ADR      = BASE_ADR + REG_DAT_OFS;
    localparam word_t BAD_ADR      = BASE_ADR + 32'h0000_0008;
    localparam int    MAX_DIV      = 9;   // Largest divider used on the serial lines.
    localparam int    WATCH_FRAMES = 14;  // Frames, with each quiet period counted as two.
    localparam int    MARGIN_CLKS  = 600;
    localparam int    TIMEOUT_NS   =
        (WATCH_FRAMES * 12 * (MAX_DIV + 2) + MARGIN_CLKS) * CLK_PERIOD;

    logic       clk;
    logic       resetn;
    word_t      adr_i;
    word_t      dat_i;
    logic [3:0] sel_i;
    logic       we_i;
    logic       cyc_i;
    logic       stb_i;
    logic       ack_o;
    word_t      dat_o;
    logic       ser_rx_i;
    logic       ser_tx_o;

    word_t       div_model;   // Divider as the testbench expects it.
    int unsigned bit_clks;    // Clocks per bit time.
    logic [9:0]  exp_frames[$];
    int          frames_seen;

    uart_top #(
        .BASE_ADR (BASE_ADR)
    ) dut0 (
        .clk      (clk),
        .resetn   (resetn),
        .adr_i    (adr_i),
        .dat_i    (dat_i),
        .sel_i    (sel_i),
        .we_i     (we_i),
        .cyc_i    (cyc_i),
        .stb_i    (stb_i),
        .ack_o    (ack_o),
        .dat_o    (dat_o),
        .ser_rx_i (ser_rx_i),
        .ser_tx_o (ser_tx_o)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // Reference model.
    function automatic word_t merge_div(input word_t old_div, input word_t new_div,
                                        input logic [3:0] sel);
        word_t mask;
        mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
        return (old_div & ~mask) | (new_div & mask);
    endfunction

    // Bits in line order from the start bit to the stop bit.
    function automatic logic [9:0] frame_bits(input byte_t data);
        logic [9:0] bits;
        bits[0] = 1'b0;
        for (int i = 0; i < 8; i++)
            bits[i + 1] = data[i];
        bits[9] = 1'b1;
        return bits;
    endfunction

    function automatic word_t expected_read(input logic valid, input byte_t data);
        return valid ? word_t'(data) : RX_EMPTY;
    endfunction

    task automatic report_failure(input string what);
        $display("Failure: %s", what);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %08h actual %08h", name, exp, act);
            $display("sim failed");
            $fatal(1, "word mismatch");
        end
    endtask

    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        if (act !== exp) begin
            $display("** Error: %s expected %02h actual %02h", name, exp, act);
            $display("sim failed");
            $fatal(1, "byte mismatch");
        end
    endtask

    // Returns 1 ns after the acked clock edge.
    task automatic wait_ack(output word_t rdata);
        @(negedge clk);
        while (ack_o !== 1'b1)
            @(negedge clk);
        rdata = dat_o;
        @(posedge clk);
        #1;
        cyc_i = 1'b0;
        stb_i = 1'b0;
        we_i  = 1'b0;
    endtask

    task automatic wb_write(input word_t adr, input word_t data, input logic [3:0] sel);
        word_t unused;
        adr_i = adr;
        dat_i = data;
        sel_i = sel;
        we_i  = 1'b1;
        cyc_i = 1'b1;
        stb_i = 1'b1;
        wait_ack(unused);
    endtask

    task automatic wb_read(input word_t adr, output word_t data);
        adr_i = adr;
        sel_i = 4'hF;
        we_i  = 1'b0;
        cyc_i = 1'b1;
        stb_i = 1'b1;
        wait_ack(data);
    endtask

    task automatic set_divider(input word_t div);
        word_t rd;
        wb_write(DIV_ADR, div, 4'hF);
        div_model = div;
        bit_clks  = div + 32'd2;
        wb_read(DIV_ADR, rd);
        check_word("divider set", div_model, rd);
    endtask

    task automatic send_serial(input byte_t data);
        logic [9:0] bits;
        bits = frame_bits(data);
        for (int i = 0; i < 10; i++) begin
            ser_rx_i = bits[i];
            repeat (bit_clks) @(posedge clk);
            #1;
        end
    endtask

    // Samples each bit in the middle, counting from the first low negedge.
    task automatic capture_frame(output logic [9:0] bits);
        @(negedge clk);
        while (ser_tx_o !== 1'b0)
            @(negedge clk);
        repeat (bit_clks / 2) @(negedge clk);
        for (int i = 0; i < 10; i++) begin
            bits[i] = ser_tx_o;
            if (i < 9)
                repeat (bit_clks) @(negedge clk);
        end
    endtask

    task automatic wait_frames(input int count);
        while (frames_seen < count)
            @(posedge clk);
        #1;
    endtask

    task automatic probe_unmapped(input word_t adr);
        adr_i = adr;
        sel_i = 4'hF;
        we_i  = 1'b0;
        cyc_i = 1'b1;
        stb_i = 1'b1;
        repeat (4 * bit_clks) begin
            @(negedge clk);
            if (ack_o !== 1'b0)
                report_failure("a cycle to an unmapped address was acknowledged");
        end
        @(posedge clk);
        #1;
        cyc_i = 1'b0;
        stb_i = 1'b0;
    endtask

    // Compares every frame on ser_tx_o with the oldest expected one.
    initial begin : tx_monitor
        logic [9:0] got;
        logic [9:0] want;
        @(posedge resetn);
        forever begin
            capture_frame(got);
            if (exp_frames.size() == 0)
                report_failure("a frame appeared on ser_tx_o without a data write");
            want = exp_frames.pop_front();
            check_word("tx start and stop", {30'd0, want[9], want[0]},
                       {30'd0, got[9], got[0]});
            check_byte("tx data", want[8:1], got[8:1]);
            frames_seen++;
        end
    end

    initial begin : watchdog
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    initial begin : main
        word_t      rd;
        word_t      wdat;
        logic [3:0] sel;
        byte_t      b0;
        byte_t      b1;
        int         seen;

        void'($urandom(SEED));
        resetn      = 1'b0;
        adr_i       = '0;
        dat_i       = '0;
        sel_i       = 4'h0;
        we_i        = 1'b0;
        cyc_i       = 1'b0;
        stb_i       = 1'b0;
        ser_rx_i    = 1'b1;   // Idle line.
        div_model   = DIV_RESET;
        bit_clks    = DIV_RESET + 32'd2;
        frames_seen = 0;
        repeat (2) @(posedge clk);
        #1;
        resetn = 1'b1;

        // Divider register and byte-lane merge.
        wb_read(DIV_ADR, rd);
        check_word("divider reset", DIV_RESET, rd);
        repeat (6) begin
            wdat = $urandom;
            sel  = 4'($urandom);
            wb_write(DIV_ADR, wdat, sel);
            div_model = merge_div(div_model, wdat, sel);
            wb_read(DIV_ADR, rd);
            check_word("divider merge", div_model, rd);
        end
        set_divider(32'd2 + ($urandom % (MAX_DIV - 1)));

        // Empty data register.
        wb_read(DAT_ADR, rd);
        check_word("rx empty", expected_read(1'b0, 8'h00), rd);

        // Single frame, sent once the quiet period is over.
        b0 = byte_t'($urandom);
        exp_frames.push_back(frame_bits(b0));
        wb_write(DAT_ADR, {24'h00_0000, b0}, 4'hF);
        wait_frames(1);

        // Back-to-back writes, the second one stalls.
        b0 = byte_t'($urandom);
        b1 = byte_t'($urandom);
        exp_frames.push_back(frame_bits(b0));
        exp_frames.push_back(frame_bits(b1));
        wb_write(DAT_ADR, {24'h00_0000, b0}, 4'hF);
        seen = frames_seen;
        wb_write(DAT_ADR, {24'h00_0000, b1}, 4'hF);
        if (frames_seen < seen + 1)
            report_failure("second data write completed before the first stop bit");
        wait_frames(seen + 2);
        repeat (bit_clks) @(posedge clk);
        #1;

        // Receive at a new bit time, then read-clear.
        set_divider(32'd2 + ($urandom % (MAX_DIV - 1)));
        repeat (2) begin
            b0 = byte_t'($urandom);
            send_serial(b0);
            wb_read(DAT_ADR, rd);
            check_word("rx data", expected_read(1'b1, b0), rd);
            wb_read(DAT_ADR, rd);
            check_word("rx read clear", expected_read(1'b0, b0), rd);
        end

        probe_unmapped(BAD_ADR);
        wb_read(DIV_ADR, rd);
        check_word("divider after unmapped", div_model, rd);

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire
